// File: source/cpuPkg.sv
package cpuPkg;

    localparam int DATA_WIDTH    = 16;
    localparam int INSTR_WIDTH   = 16;
    localparam int ADDR_WIDTH    = 8;
    localparam int REG_COUNT     = 16;
    localparam int REG_IDX_WIDTH = 4;
    localparam int IMM8_WIDTH    = 8;

    // Instruction field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RS_MSB     = 11;
    localparam int RS_LSB     = 8;
    localparam int RT_MSB     = 7;
    localparam int RT_LSB     = 4;
    localparam int RD_MSB     = 3;
    localparam int RD_LSB     = 0;
    localparam int IMM_MSB    = 7;
    localparam int IMM_LSB    = 0;

    typedef logic [DATA_WIDTH-1:0]    dataWord_t;
    typedef logic [INSTR_WIDTH-1:0]   instrWord_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [REG_IDX_WIDTH-1:0] regIdx_t;
    typedef logic [IMM8_WIDTH-1:0]    imm8_t;

    // Unlisted codes decode as NOP
    typedef enum logic [3:0] {
        LW   = 4'd0,
        SW   = 4'd1,
        ADD  = 4'd2,
        MOV  = 4'd3,
        SUB  = 4'd4,
        JMPZ = 4'd5,
        JUMP = 4'd6,
        STOP = 4'd7,
        SLT  = 4'd10,
        NOP  = 4'd15
    } opcode_t;

    typedef enum logic [1:0] {ADD_OP, SUB_OP, SLT_OP} aluOp_t;

    typedef enum logic [1:0] {FROM_REG, FROM_MEM, FROM_WB} fwdSel_t;

endpackage

// File: source/fetchStage.sv
`timescale 1ns/10ps

module fetchStage #(
    parameter int ADDR_WIDTH = cpuPkg::ADDR_WIDTH
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start_i,
    input  logic          stallFD_i,
    input  logic          flushFD_i,
    input  logic          redirect_i,
    input  cpuPkg::addr_t redirectAddr_i,
    input  logic          halt_i,
    output cpuPkg::addr_t imAddr_o,
    output logic          imRd_o,
    output cpuPkg::addr_t pcD_o,
    output logic          validD_o,
    output logic          halted_o
);
    import cpuPkg::*;

    typedef enum logic [1:0] {IDLE, RUNNING, HALTED} runState_t;

    runState_t runState;
    addr_t     pc;
    logic      launch;

    assign launch = start_i && (runState != RUNNING);

    always_ff @(posedge clk)
    begin
        if (rst)
            runState <= IDLE;
        else if (halt_i)
            runState <= HALTED;
        else if (launch)
            runState <= RUNNING;
    end

    always_ff @(posedge clk)
    begin
        if (rst || launch)
            pc <= '0;
        else if (redirect_i)
            pc <= redirectAddr_i;
        else if (runState == RUNNING && !stallFD_i)
            pc <= pc + ADDR_WIDTH'(1);
    end

    // Re-read the held instruction while decode stalls
    assign imAddr_o = stallFD_i ? pcD_o : pc;
    assign imRd_o   = (runState == RUNNING);
    assign halted_o = (runState == HALTED);

    always_ff @(posedge clk)
    begin
        pcD_o <= imAddr_o;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            validD_o <= 1'b0;
        else
            validD_o <= imRd_o && !flushFD_i;
    end

endmodule

// File: source/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
    input  logic               clk,
    input  logic               rst,
    input  cpuPkg::instrWord_t instr_i,
    input  logic               validD_i,
    input  logic               bubbleE_i,
    input  logic               flushE_i,
    input  cpuPkg::dataWord_t  readA_i,
    input  cpuPkg::dataWord_t  readB_i,
    output cpuPkg::regIdx_t    rsD_o,
    output cpuPkg::regIdx_t    rtD_o,
    output logic               readsRtD_o,
    output cpuPkg::regIdx_t    rsE_o,
    output cpuPkg::regIdx_t    rtE_o,
    output cpuPkg::regIdx_t    dstE_o,
    output cpuPkg::imm8_t      imm8E_o,
    output cpuPkg::dataWord_t  opA_o,
    output cpuPkg::dataWord_t  opB_o,
    output logic               regWriteE_o,
    output cpuPkg::aluOp_t     aluOpE_o,
    output logic               memReadE_o,
    output logic               memWriteE_o,
    output logic               movE_o,
    output logic               jumpE_o,
    output logic               branchZE_o,
    output logic               stopE_o
);
    import cpuPkg::*;

    opcode_t opcode;
    regIdx_t rdD;
    aluOp_t  aluOp;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    mov;
    logic    jump;
    logic    branchZ;
    logic    stop;
    logic    writesRs;
    logic    kill;

    assign opcode = opcode_t'(instr_i[OPCODE_MSB:OPCODE_LSB]);
    assign rsD_o  = instr_i[RS_MSB:RS_LSB];
    assign rtD_o  = instr_i[RT_MSB:RT_LSB];
    assign rdD    = instr_i[RD_MSB:RD_LSB];

    always_comb
    begin
        regWrite   = 1'b0;
        aluOp      = ADD_OP;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        mov        = 1'b0;
        jump       = 1'b0;
        branchZ    = 1'b0;
        stop       = 1'b0;
        writesRs   = 1'b0;
        readsRtD_o = 1'b0;
        case (opcode)
            ADD, SUB, SLT:
            begin
                regWrite   = 1'b1;
                readsRtD_o = 1'b1;
                if (opcode == SUB)
                    aluOp = SUB_OP;
                else if (opcode == SLT)
                    aluOp = SLT_OP;
            end
            MOV:
            begin
                regWrite = 1'b1;
                mov      = 1'b1;
                writesRs = 1'b1;
            end
            LW:
            begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                writesRs = 1'b1;
            end
            SW:      memWrite = 1'b1;
            JUMP:    jump = 1'b1;
            JMPZ:    branchZ = 1'b1;
            STOP:    stop = 1'b1;
            default: ;
        endcase
    end

    // Empty, squashed or stalled slots enter execute as NOP
    assign kill = !validD_i || bubbleE_i || flushE_i;

    always_ff @(posedge clk)
    begin
        if (rst || kill)
        begin
            regWriteE_o <= 1'b0;
            memReadE_o  <= 1'b0;
            memWriteE_o <= 1'b0;
            movE_o      <= 1'b0;
            jumpE_o     <= 1'b0;
            branchZE_o  <= 1'b0;
            stopE_o     <= 1'b0;
        end
        else
        begin
            regWriteE_o <= regWrite;
            memReadE_o  <= memRead;
            memWriteE_o <= memWrite;
            movE_o      <= mov;
            jumpE_o     <= jump;
            branchZE_o  <= branchZ;
            stopE_o     <= stop;
        end
    end

    always_ff @(posedge clk)
    begin
        rsE_o    <= rsD_o;
        rtE_o    <= rtD_o;
        dstE_o   <= writesRs ? rsD_o : rdD;
        imm8E_o  <= instr_i[IMM_MSB:IMM_LSB];
        opA_o    <= readA_i;
        opB_o    <= readB_i;
        aluOpE_o <= aluOp;
    end

endmodule

// File: source/registerFile.sv
`timescale 1ns/10ps

module registerFile #(
    parameter int DATA_WIDTH = cpuPkg::DATA_WIDTH,
    parameter int REG_COUNT  = cpuPkg::REG_COUNT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cpuPkg::regIdx_t       readIdxA_i,
    input  cpuPkg::regIdx_t       readIdxB_i,
    input  logic                  writeEn_i,
    input  cpuPkg::regIdx_t       writeIdx_i,
    input  logic [DATA_WIDTH-1:0] writeData_i,
    output logic [DATA_WIDTH-1:0] readA_o,
    output logic [DATA_WIDTH-1:0] readB_o
);

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (writeEn_i)
            regs[writeIdx_i] <= writeData_i;
    end

    // Same-cycle writeback bypasses the array
    assign readA_o = (writeEn_i && writeIdx_i == readIdxA_i) ? writeData_i : regs[readIdxA_i];
    assign readB_o = (writeEn_i && writeIdx_i == readIdxB_i) ? writeData_i : regs[readIdxB_i];

endmodule

// File: source/executeStage.sv
`timescale 1ns/10ps

module executeStage #(
    parameter int DATA_WIDTH = cpuPkg::DATA_WIDTH
) (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::regIdx_t   dstE_i,
    input  cpuPkg::imm8_t     imm8E_i,
    input  cpuPkg::dataWord_t opA_i,
    input  cpuPkg::dataWord_t opB_i,
    input  logic              regWriteE_i,
    input  cpuPkg::aluOp_t    aluOpE_i,
    input  logic              memReadE_i,
    input  logic              memWriteE_i,
    input  logic              movE_i,
    input  logic              jumpE_i,
    input  logic              branchZE_i,
    input  logic              stopE_i,
    input  cpuPkg::fwdSel_t   fwdSelA_i,
    input  cpuPkg::fwdSel_t   fwdSelB_i,
    input  cpuPkg::dataWord_t memResult_i,
    input  cpuPkg::dataWord_t wbData_i,
    output logic              redirect_o,
    output cpuPkg::addr_t     redirectAddr_o,
    output logic              halt_o,
    output cpuPkg::regIdx_t   dstM_o,
    output logic              regWriteM_o,
    output logic              memReadM_o,
    output logic              memWriteM_o,
    output cpuPkg::imm8_t     imm8M_o,
    output cpuPkg::dataWord_t resultM_o,
    output cpuPkg::dataWord_t storeDataM_o
);
    import cpuPkg::*;

    dataWord_t srcA;
    dataWord_t srcB;
    dataWord_t aluResult;
    dataWord_t signExt;

    function automatic dataWord_t pickOperand(fwdSel_t sel, dataWord_t regValue,
                                              dataWord_t memValue, dataWord_t wbValue);
        case (sel)
            FROM_MEM: return memValue;
            FROM_WB:  return wbValue;
            default:  return regValue;
        endcase
    endfunction

    assign srcA = pickOperand(fwdSelA_i, opA_i, memResult_i, wbData_i);
    assign srcB = pickOperand(fwdSelB_i, opB_i, memResult_i, wbData_i);

    always_comb
    begin
        case (aluOpE_i)
            SUB_OP:  aluResult = srcA - srcB;
            SLT_OP:  aluResult = dataWord_t'(srcA < srcB);
            default: aluResult = srcA + srcB;
        endcase
    end

    assign signExt = {{(DATA_WIDTH-IMM8_WIDTH){imm8E_i[IMM8_WIDTH-1]}}, imm8E_i};

    // Control transfers resolve here, two younger slots get squashed
    assign redirect_o     = jumpE_i || (branchZE_i && srcA == '0);
    assign redirectAddr_o = addr_t'(imm8E_i);
    assign halt_o         = stopE_i;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            regWriteM_o <= 1'b0;
            memReadM_o  <= 1'b0;
            memWriteM_o <= 1'b0;
        end
        else
        begin
            regWriteM_o <= regWriteE_i;
            memReadM_o  <= memReadE_i;
            memWriteM_o <= memWriteE_i;
        end
    end

    always_ff @(posedge clk)
    begin
        dstM_o       <= dstE_i;
        imm8M_o      <= imm8E_i;
        resultM_o    <= movE_i ? signExt : aluResult;
        // SW stores rs
        storeDataM_o <= srcA;
    end

endmodule

// File: source/memoryStage.sv
`timescale 1ns/10ps

module memoryStage (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::regIdx_t   dstM_i,
    input  logic              regWriteM_i,
    input  logic              memReadM_i,
    input  logic              memWriteM_i,
    input  cpuPkg::imm8_t     imm8M_i,
    input  cpuPkg::dataWord_t resultM_i,
    input  cpuPkg::dataWord_t storeDataM_i,
    input  cpuPkg::dataWord_t dmRData_i,
    output cpuPkg::addr_t     dmAddr_o,
    output logic              dmRd_o,
    output logic              dmWr_o,
    output cpuPkg::dataWord_t dmWData_o,
    output cpuPkg::dataWord_t memResult_o,
    output logic              wbWrite_o,
    output cpuPkg::regIdx_t   wbIdx_o,
    output cpuPkg::dataWord_t wbData_o
);
    import cpuPkg::*;

    dataWord_t resultW;
    logic      loadW;

    assign dmAddr_o    = addr_t'(imm8M_i);
    assign dmRd_o      = memReadM_i;
    assign dmWr_o      = memWriteM_i;
    assign dmWData_o   = storeDataM_i;
    assign memResult_o = resultM_i;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbWrite_o <= 1'b0;
            loadW     <= 1'b0;
        end
        else
        begin
            wbWrite_o <= regWriteM_i;
            loadW     <= memReadM_i;
        end
    end

    always_ff @(posedge clk)
    begin
        wbIdx_o <= dstM_i;
        resultW <= resultM_i;
    end

    // Load data arrives from memory during writeback
    assign wbData_o = loadW ? dmRData_i : resultW;

    assert property (@(posedge clk) disable iff (rst) !(dmRd_o && dmWr_o))
        else $error("data memory read and write in the same cycle");

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::regIdx_t rsD_i,
    input  cpuPkg::regIdx_t rtD_i,
    input  logic            readsRtD_i,
    input  cpuPkg::regIdx_t rsE_i,
    input  cpuPkg::regIdx_t rtE_i,
    input  logic            memReadE_i,
    input  logic            redirect_i,
    input  logic            halt_i,
    input  cpuPkg::regIdx_t dstM_i,
    input  logic            regWriteM_i,
    input  logic            memReadM_i,
    input  cpuPkg::regIdx_t wbIdx_i,
    input  logic            wbWrite_i,
    output cpuPkg::fwdSel_t fwdSelA_o,
    output cpuPkg::fwdSel_t fwdSelB_o,
    output logic            stallFD_o,
    output logic            bubbleE_o,
    output logic            flushFD_o
);
    import cpuPkg::*;

    logic loadUse;

    // Memory stage wins unless it holds a load
    function automatic fwdSel_t forwardFrom(regIdx_t srcIdx);
        if (regWriteM_i && !memReadM_i && dstM_i == srcIdx)
            return FROM_MEM;
        if (wbWrite_i && wbIdx_i == srcIdx)
            return FROM_WB;
        return FROM_REG;
    endfunction

    always_comb
    begin
        fwdSelA_o = forwardFrom(rsE_i);
        fwdSelB_o = forwardFrom(rtE_i);
    end

    // LW writes its rs field
    assign loadUse = memReadE_i && (rsD_i == rsE_i || (readsRtD_i && rtD_i == rsE_i));

    assign stallFD_o = loadUse;
    assign bubbleE_o = loadUse;
    assign flushFD_o = redirect_i || halt_i;

    assert property (@(posedge clk) disable iff (rst) loadUse |-> !redirect_i)
        else $error("load-use stall during a redirect");

    assert property (@(posedge clk) disable iff (rst) loadUse |=> !memReadE_i)
        else $error("load-use stall did not put a bubble into execute");

endmodule

// File: source/pipelinedCpu.sv
`timescale 1ns/10ps

module pipelinedCpu #(
    parameter int DATA_WIDTH = cpuPkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = cpuPkg::ADDR_WIDTH,
    parameter int REG_COUNT  = cpuPkg::REG_COUNT
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  cpuPkg::instrWord_t imData_i,
    input  cpuPkg::dataWord_t  dmRData_i,
    output logic               halted_o,
    output cpuPkg::addr_t      imAddr_o,
    output logic               imRd_o,
    output cpuPkg::addr_t      dmAddr_o,
    output logic               dmRd_o,
    output logic               dmWr_o,
    output cpuPkg::dataWord_t  dmWData_o
);
    import cpuPkg::*;

    // Hazard control
    logic    stallFD;
    logic    flushFD;
    logic    bubbleE;
    fwdSel_t fwdSelA;
    fwdSel_t fwdSelB;

    // Fetch and decode
    logic    validD;
    logic    redirect;
    logic    halt;
    addr_t   redirectAddr;
    regIdx_t rsD;
    regIdx_t rtD;
    logic    readsRtD;
    dataWord_t readA;
    dataWord_t readB;

    // ID/EX
    regIdx_t   rsE;
    regIdx_t   rtE;
    regIdx_t   dstE;
    imm8_t     imm8E;
    dataWord_t opA;
    dataWord_t opB;
    aluOp_t    aluOpE;
    logic      regWriteE;
    logic      memReadE;
    logic      memWriteE;
    logic      movE;
    logic      jumpE;
    logic      branchZE;
    logic      stopE;

    // EX/MEM and writeback
    regIdx_t   dstM;
    logic      regWriteM;
    logic      memReadM;
    logic      memWriteM;
    imm8_t     imm8M;
    dataWord_t resultM;
    dataWord_t storeDataM;
    dataWord_t memResult;
    logic      wbWrite;
    regIdx_t   wbIdx;
    dataWord_t wbData;

    fetchStage #(.ADDR_WIDTH(ADDR_WIDTH)) fetch_i (
        .clk, .rst, .start_i,
        .stallFD_i(stallFD), .flushFD_i(flushFD),
        .redirect_i(redirect), .redirectAddr_i(redirectAddr), .halt_i(halt),
        .imAddr_o, .imRd_o, .pcD_o(), .validD_o(validD), .halted_o
    );

    decodeStage decode_i (
        .clk, .rst, .instr_i(imData_i), .validD_i(validD),
        .bubbleE_i(bubbleE), .flushE_i(flushFD), .readA_i(readA), .readB_i(readB),
        .rsD_o(rsD), .rtD_o(rtD), .readsRtD_o(readsRtD),
        .rsE_o(rsE), .rtE_o(rtE), .dstE_o(dstE), .imm8E_o(imm8E), .opA_o(opA), .opB_o(opB),
        .regWriteE_o(regWriteE), .aluOpE_o(aluOpE), .memReadE_o(memReadE),
        .memWriteE_o(memWriteE), .movE_o(movE), .jumpE_o(jumpE),
        .branchZE_o(branchZE), .stopE_o(stopE)
    );

    registerFile #(.DATA_WIDTH(DATA_WIDTH), .REG_COUNT(REG_COUNT)) regFile_i (
        .clk, .rst, .readIdxA_i(rsD), .readIdxB_i(rtD),
        .writeEn_i(wbWrite), .writeIdx_i(wbIdx), .writeData_i(wbData),
        .readA_o(readA), .readB_o(readB)
    );

    executeStage #(.DATA_WIDTH(DATA_WIDTH)) execute_i (
        .clk, .rst, .dstE_i(dstE), .imm8E_i(imm8E), .opA_i(opA), .opB_i(opB),
        .regWriteE_i(regWriteE), .aluOpE_i(aluOpE), .memReadE_i(memReadE),
        .memWriteE_i(memWriteE), .movE_i(movE), .jumpE_i(jumpE),
        .branchZE_i(branchZE), .stopE_i(stopE),
        .fwdSelA_i(fwdSelA), .fwdSelB_i(fwdSelB), .memResult_i(memResult), .wbData_i(wbData),
        .redirect_o(redirect), .redirectAddr_o(redirectAddr), .halt_o(halt),
        .dstM_o(dstM), .regWriteM_o(regWriteM), .memReadM_o(memReadM),
        .memWriteM_o(memWriteM), .imm8M_o(imm8M), .resultM_o(resultM),
        .storeDataM_o(storeDataM)
    );

    memoryStage memory_i (
        .clk, .rst, .dstM_i(dstM), .regWriteM_i(regWriteM), .memReadM_i(memReadM),
        .memWriteM_i(memWriteM), .imm8M_i(imm8M), .resultM_i(resultM),
        .storeDataM_i(storeDataM), .dmRData_i,
        .dmAddr_o, .dmRd_o, .dmWr_o, .dmWData_o, .memResult_o(memResult),
        .wbWrite_o(wbWrite), .wbIdx_o(wbIdx), .wbData_o(wbData)
    );

    hazardUnit hazard_i (
        .clk, .rst, .rsD_i(rsD), .rtD_i(rtD), .readsRtD_i(readsRtD),
        .rsE_i(rsE), .rtE_i(rtE), .memReadE_i(memReadE),
        .redirect_i(redirect), .halt_i(halt),
        .dstM_i(dstM), .regWriteM_i(regWriteM), .memReadM_i(memReadM),
        .wbIdx_i(wbIdx), .wbWrite_i(wbWrite),
        .fwdSelA_o(fwdSelA), .fwdSelB_o(fwdSelB),
        .stallFD_o(stallFD), .bubbleE_o(bubbleE), .flushFD_o(flushFD)
    );

endmodule

// File: verif/cpuPrograms.svh
// One row per program, padded with NOP words
localparam int PROG_COUNT = 5;
localparam int PROG_WORDS = 16;
localparam int DATA_WORDS = 4;
localparam int MAX_STORES = 6;
localparam int DATA_BASE  = 'h40;

localparam logic [15:0] PROGRAMS [PROG_COUNT][PROG_WORDS] = '{
    // Dependent ADD, SUB, SLT chain
    '{16'h3105, 16'h3203, 16'h2123, 16'h4314, 16'hA435, 16'hA346, 16'h2537, 16'h4218,
      16'h1815, 16'h1310, 16'h1411, 16'h1512, 16'h1613, 16'h1714, 16'h7000, 16'hF000},
    // Negative MOV and load-use pairs
    '{16'h3180, 16'h32FF, 16'h0340, 16'h2314, 16'h0541, 16'h2256, 16'h1120, 16'h1221,
      16'h1422, 16'h1623, 16'h377F, 16'h1724, 16'h0840, 16'h1825, 16'h7000, 16'hF000},
    // JUMP over stores
    '{16'h3111, 16'h6005, 16'h1130, 16'h3122, 16'h1131, 16'h1132, 16'h3233, 16'h600A,
      16'h1233, 16'h7000, 16'h1234, 16'h7000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
    // JMPZ taken, not taken, and taken on a forwarded zero
    '{16'h320A, 16'h5104, 16'h1250, 16'h7000, 16'h1251, 16'h5208, 16'h1252, 16'h6009,
      16'h1253, 16'h4223, 16'h530D, 16'h1254, 16'h7000, 16'h1255, 16'h7000, 16'hF000},
    // Stores right before STOP, more stores after it
    '{16'h3144, 16'h3255, 16'h1160, 16'h1261, 16'h7000, 16'h1162, 16'h1263, 16'h7000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000}
};

// Loaded at DATA_BASE
localparam logic [15:0] INIT_DATA [PROG_COUNT][DATA_WORDS] = '{
    '{16'h0000, 16'h0001, 16'h0002, 16'h0003},
    '{16'h1234, 16'h0100, 16'h5A5A, 16'hC3C3},
    '{16'h0F0F, 16'hF0F0, 16'h1111, 16'h2222},
    '{16'hAAAA, 16'h5555, 16'h0000, 16'hFFFF},
    '{16'h7777, 16'h8888, 16'h9999, 16'h6666}
};

// Stores in program order as {address, value}
localparam logic [23:0] EXPECTED_STORES [PROG_COUNT][MAX_STORES] = '{
    '{24'h15_FFFE, 24'h10_0008, 24'h11_0003, 24'h12_0001, 24'h13_0000, 24'h14_0009},
    '{24'h20_FF80, 24'h21_FFFF, 24'h22_11B4, 24'h23_00FF, 24'h24_007F, 24'h25_1234},
    '{24'h32_0011, 24'h34_0033, 24'h00_0000, 24'h00_0000, 24'h00_0000, 24'h00_0000},
    '{24'h51_000A, 24'h52_000A, 24'h55_000A, 24'h00_0000, 24'h00_0000, 24'h00_0000},
    '{24'h60_0044, 24'h61_0055, 24'h00_0000, 24'h00_0000, 24'h00_0000, 24'h00_0000}
};

localparam int STORE_COUNTS [PROG_COUNT] = '{6, 6, 2, 3, 2};

// File: verif/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    `include "cpuPrograms.svh"

    localparam int TIMEOUT_CYCLES = 500;
    localparam int MEM_WORDS      = 256;

    logic       clk;
    logic       rst;
    logic       start;
    instrWord_t imData;
    dataWord_t  dmRData;
    logic       halted;
    addr_t      imAddr;
    logic       imRd;
    addr_t      dmAddr;
    logic       dmRd;
    logic       dmWr;
    dataWord_t  dmWData;

    instrWord_t instrMem [MEM_WORDS];
    dataWord_t  dataMem [MEM_WORDS];

    // Requests seen during the cycle before an edge
    addr_t     imAddrQ;
    logic      imRdQ;
    addr_t     dmAddrQ;
    logic      dmRdQ;
    logic      dmWrQ;
    dataWord_t dmWDataQ;

    logic [23:0] seenStores [$];
    logic        capturing;
    int          seed;

    pipelinedCpu #(
        .DATA_WIDTH(16),
        .ADDR_WIDTH(8),
        .REG_COUNT(16)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .start_i(start),
        .imData_i(imData),
        .dmRData_i(dmRData),
        .halted_o(halted),
        .imAddr_o(imAddr),
        .imRd_o(imRd),
        .dmAddr_o(dmAddr),
        .dmRd_o(dmRd),
        .dmWr_o(dmWr),
        .dmWData_o(dmWData)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
            abortRun($sformatf("[FAIL] t=%0t %s actual=%0h expected=%0h",
                               $time, name, actual, expected));
    endtask

    // Both memories answer one cycle after the request
    initial
    begin
        imData  = 16'hF000;
        dmRData = '0;
        forever
        begin
            @(posedge clk);
            #2;
            if (dmWrQ)
                dataMem[dmAddrQ] = dmWDataQ;
            if (imRdQ)
                imData = instrMem[imAddrQ];
            if (dmRdQ)
                dmRData = dataMem[dmAddrQ];
        end
    end

    always @(negedge clk)
    begin
        imAddrQ  = imAddr;
        imRdQ    = imRd && !rst;
        dmAddrQ  = dmAddr;
        dmRdQ    = dmRd && !rst;
        dmWrQ    = dmWr && !rst;
        dmWDataQ = dmWData;
        if (capturing && dmWr)
        begin
            if (halted)
                abortRun($sformatf("store to address %h seen after halted_o rose", dmAddr));
            else
                seenStores.push_back({dmAddr, dmWData});
        end
    end

    task automatic loadMemories(input int p);
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            // Opcode F is a NOP, low byte tags the address
            instrMem[addr_t'(a)] = {8'hF0, 8'(a)};
            dataMem[addr_t'(a)]  = 16'($random(seed));
        end
        for (int w = 0; w < PROG_WORDS; w++)
            instrMem[addr_t'(w)] = PROGRAMS[p][w];
        for (int w = 0; w < DATA_WORDS; w++)
            dataMem[addr_t'(DATA_BASE + w)] = INIT_DATA[p][w];
    endtask

    task automatic runProgram(input int p);
        int          cycles;
        logic [23:0] expected;
        @(posedge clk);
        #2;
        rst       = 1'b1;
        start     = 1'b0;
        capturing = 1'b0;
        loadMemories(p);
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle until start
        repeat (3)
        begin
            @(negedge clk);
            checkValue("halted_o", halted, 0);
            checkValue("imRd_o", imRd, 0);
            checkValue("dmRd_o", dmRd, 0);
            checkValue("dmWr_o", dmWr, 0);
        end

        @(posedge clk);
        #2;
        seenStores.delete();
        capturing = 1'b1;
        start     = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;

        cycles = 0;
        while (!halted)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abortRun($sformatf("program %0d: halted_o did not rise within %0d cycles",
                                   p, TIMEOUT_CYCLES));
        end

        // Window for stray stores after the halt
        repeat (4) @(negedge clk);

        if (seenStores.size() < STORE_COUNTS[p])
            abortRun($sformatf("program %0d: only %0d of %0d expected stores appeared",
                               p, seenStores.size(), STORE_COUNTS[p]));
        else if (seenStores.size() > STORE_COUNTS[p])
            abortRun($sformatf("program %0d: %0d stores seen but only %0d expected",
                               p, seenStores.size(), STORE_COUNTS[p]));
        else
        begin
            for (int s = 0; s < STORE_COUNTS[p]; s++)
            begin
                expected = EXPECTED_STORES[p][s];
                checkValue("dmAddr_o", seenStores[s][23:16], expected[23:16]);
                checkValue("dmWData_o", seenStores[s][15:0], expected[15:0]);
            end
        end
    endtask

    initial
    begin
        seed      = 12881;
        rst       = 1'b1;
        start     = 1'b0;
        capturing = 1'b0;
        for (int p = 0; p < PROG_COUNT; p++)
            runProgram(p);
        $display("Test passed");
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/registerFile.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/pipelinedCpu.sv
verif/cpuTb.sv

// File: run.sh
#!/bin/sh
# Builds the cpuTb simulation with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    --top-module cpuTb -Mdir obj_dir -o cpuSim -f project.f

output=$(./obj_dir/cpuSim) || true
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "run.sh: pass message not found in simulation output" >&2
exit 1
